// File: vlog.f
+incdir+design
+incdir+tb
design/rv_front_pkg.sv
design/rv_fetch_unit.sv
design/rv_fetch_buffer.sv
design/rv_decode_stage.sv
design/rv_front_end.sv
tb/rv_front_checker.sv
tb/rv_front_tb.sv

// File: Bender.yml
package:
  name: rv_front

sources:
  # Front-end RTL
  - include_dirs:
      - design
    files:
      - design/rv_front_pkg.sv
      - design/rv_fetch_unit.sv
      - design/rv_fetch_buffer.sv
      - design/rv_decode_stage.sv
      - design/rv_front_end.sv
  # Testbench and bound checker
  - target: test
    include_dirs:
      - design
      - tb
    files:
      - tb/rv_front_checker.sv
      - tb/rv_front_tb.sv

// File: tb/rv_front_tb_mem.svh
// Program image and expected-decode rule, included inside the testbench and checker modules

    // 16-word program, repeats every 64 bytes, covers every decode class
    function automatic word_t image_word(input addr_t addr);
        case (addr[5:2])
            // ALU, load and store
            4'd0:    return 32'hffb0_0093;
            4'd1:    return 32'h0020_81b3;
            4'd2:    return 32'h0081_2283;
            4'd3:    return 32'hfe51_2e23;
            // Control flow
            4'd4:    return 32'hfe20_88e3;
            4'd5:    return 32'h0010_00ef;
            4'd6:    return 32'h0000_8067;
            4'd7:    return 32'h1234_53b7;
            4'd8:    return 32'hffff_f417;
            // ECALL, fence, EBREAK, CSR read, illegal
            4'd9:    return 32'h0000_0073;
            4'd10:   return 32'h0ff0_000f;
            4'd11:   return 32'h0010_0073;
            4'd12:   return 32'h3000_2573;
            4'd13:   return 32'h0000_0000;
            4'd14:   return 32'hfff4_c493;
            default: return 32'h0041_9663;
        endcase
    endfunction

    // ECALL or EBREAK: system opcode, funct3 zero, bits 31:20 equal to 0 or 1
    function automatic logic is_halt_word(input word_t w);
        return (w[6:0] == 7'h73) && (w[14:12] == 3'b000) && (w[31:21] == 11'd0);
    endfunction

    // Decoded item expected for the word at pc
    function automatic dec_item_t expect_decode(input addr_t pc);
        word_t     w;
        word_t     sx;
        dec_item_t d;
        w        = image_word(pc);
        // All ones when the instruction sign bit is set
        sx       = {32{w[31]}};
        d.pc     = pc;
        d.rd     = w[11:7];
        d.rs1    = w[19:15];
        d.rs2    = w[24:20];
        d.funct3 = w[14:12];
        case (w[6:0])
            7'h33:   d.op_class = r_alu;
            7'h13:   d.op_class = i_alu;
            7'h03:   d.op_class = load;
            7'h23:   d.op_class = store;
            7'h63:   d.op_class = branch;
            7'h6f:   d.op_class = jal;
            7'h67:   d.op_class = jalr;
            7'h37:   d.op_class = lui;
            7'h17:   d.op_class = auipc;
            7'h73:   d.op_class = system;
            7'h0f:   d.op_class = fence;
            default: d.op_class = illegal;
        endcase
        // Immediate by format, sign bit replicated above the field
        case (d.op_class)
            store:          d.imm = (sx << 12) | {w[31:25], w[11:7]};
            branch:         d.imm = (sx << 12) | (w[7] << 11) | (w[30:25] << 5) | (w[11:8] << 1);
            jal:            d.imm = (sx << 20) | (w[19:12] << 12) | (w[20] << 11) | (w[30:21] << 1);
            lui, auipc:     d.imm = w & 32'hffff_f000;
            r_alu, illegal: d.imm = '0;
            default:        d.imm = (sx << 12) | w[31:20];
        endcase
        // Everything but stores, branches, system, fence and illegal writes rd
        d.reg_write = !(d.op_class inside {store, branch, system, fence, illegal});
        return d;
    endfunction

// File: tb/rv_front_tb.sv
// Testbench top for the front end: clock, reset, memory model, hold and redirect stimulus
`timescale 1ns/1ps

module rv_front_tb import rv_front_pkg::*; ();

    `include "rv_front_tb_mem.svh"

    localparam int num_redirects = 60;
    localparam int redirect_gap  = 40;
    // Room for reset, fetch ramp-up and the final drain
    localparam int max_cycles    = num_redirects * redirect_gap + 600;

    logic      clk;
    logic      rstn;
    logic      mem_req;
    addr_t     mem_addr;
    logic      mem_ready;
    word_t     mem_rdata;
    logic      redirect;
    addr_t     redirect_pc;
    logic      hold;
    logic      dec_valid;
    dec_item_t dec_item;
    logic      halt;

    // Memory model: read accepted, idle cycles left
    logic      busy;
    int        delay = 0;
    int        cycles = 0;

    rv_front_end u_dut (
        .clk         (clk),
        .rstn        (rstn),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_ready   (mem_ready),
        .mem_rdata   (mem_rdata),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .hold        (hold),
        .dec_valid   (dec_valid),
        .dec_item    (dec_item),
        .halt        (halt)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ##########################################################
    // Memory responder, 0 to 3 idle cycles per read
    // ##########################################################

    always @(posedge clk) begin
        if (!rstn) begin
            busy = 1'b0;
            mem_ready <= 1'b0;
        end else if (mem_ready) begin
            mem_ready <= 1'b0;
        end else if (busy || mem_req) begin
            if (!busy) begin
                busy  = 1'b1;
                delay = $urandom_range(3, 0);
            end
            if (delay == 0) begin
                busy = 1'b0;
                mem_ready <= 1'b1;
                mem_rdata <= image_word(mem_addr);
            end else begin
                delay = delay - 1;
            end
        end
    end

    // Random hold, redirect released
    task automatic drive_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            hold     <= ($urandom_range(99, 0) < 30);
            redirect <= 1'b0;
        end
    endtask

    // ##########################################################
    // Main sequence
    // ##########################################################

    initial begin
        addr_t target;
        void'($urandom(32'hcd05_7273));
        rstn        = 1'b0;
        mem_ready   = 1'b0;
        mem_rdata   = '0;
        redirect    = 1'b0;
        redirect_pc = '0;
        hold        = 1'b0;
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        for (int i = 0; i < num_redirects; i++) begin
            drive_cycles($urandom_range(redirect_gap + 4, redirect_gap - 8));
            target      = $urandom;
            target[1:0] = 2'b00;
            // Every other redirect lands on a read in flight, hold keeps moving meanwhile
            do drive_cycles(1); while ((i % 2 == 0) && !mem_req);
            redirect    <= 1'b1;
            redirect_pc <= target;
        end
        drive_cycles(50);
        // Past the edge, so failures of the last sampled cycle are counted
        @(negedge clk);
        if (u_dut.u_checker.err_count == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("Something failed");
            $fatal(1, "Checker reported failed assertions");
        end
    end

    // Stop at the first failed assertion
    always @(posedge clk) begin
        if (u_dut.u_checker.err_count != 0) begin
            $display("Something failed");
            $fatal(1, "Checker assertion failed");
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles == max_cycles) begin
            $display("Run timed out after %0d cycles", max_cycles);
            $display("Something failed");
            $fatal(1, "Timeout");
        end
    end

endmodule

// File: tb/rv_front_checker.sv
// Concurrent assertions on the front-end ports, bound into the top level by the bind below
`timescale 1ns/1ps
`include "rv_front_config.svh"

module rv_front_checker import rv_front_pkg::*; (
    input logic      clk,
    input logic      rstn,
    input logic      mem_req,
    input addr_t     mem_addr,
    input logic      mem_ready,
    input logic      redirect,
    input addr_t     redirect_pc,
    input logic      hold,
    input logic      dec_valid,
    input dec_item_t dec_item,
    input logic      halt
);

    `include "rv_front_tb_mem.svh"

    // Failed assertions so far, watched by the testbench
    int unsigned err_count = 0;
    // A request has been seen since reset
    logic        seen_req;
    // Previous cycle's output valid and hold
    logic        dv_q;
    logic        hold_q;
    // Pc the next new decoded item must carry
    addr_t       exp_pc;
    logic        new_item;

    // Output was not frozen last cycle, so a valid item now is a fresh one
    assign new_item = dec_valid && !(dv_q && hold_q);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            seen_req <= 1'b0;
            dv_q     <= 1'b0;
            hold_q   <= 1'b0;
            exp_pc   <= `RV_PC_RESET;
        end else begin
            seen_req <= seen_req || mem_req;
            dv_q     <= dec_valid;
            hold_q   <= hold;
            // Redirect restarts the stream at its target
            if (redirect) begin
                exp_pc <= redirect_pc;
            end else if (new_item) begin
                exp_pc <= dec_item.pc + 32'd4;
            end
        end
    end

    // ##########################################################
    // Reset and memory port
    // ##########################################################

    a_reset_quiet: assert property (@(posedge clk) $rose(rstn) |-> !mem_req && !dec_valid && !halt)
        else begin
            err_count++;
            $error("** Error at %0t: outputs not idle after reset", $time);
        end

    a_first_addr: assert property (@(posedge clk) disable iff (!rstn)
        mem_req && !seen_req |-> mem_addr == `RV_PC_RESET)
        else begin
            err_count++;
            $error("** Error at %0t: first fetch address %h", $time, $sampled(mem_addr));
        end

    // Request and address held until the ready cycle
    a_req_held: assert property (@(posedge clk) disable iff (!rstn)
        mem_req && !mem_ready |=> $stable(mem_addr) && (mem_req || mem_ready))
        else begin
            err_count++;
            $error("** Error at %0t: request or address changed before ready", $time);
        end

    a_req_low_ready: assert property (@(posedge clk) disable iff (!rstn) mem_ready |-> !mem_req)
        else begin
            err_count++;
            $error("** Error at %0t: mem_req high in a ready cycle", $time);
        end

    // ##########################################################
    // Decode output
    // ##########################################################

    a_pc_order: assert property (@(posedge clk) disable iff (!rstn) new_item |-> dec_item.pc == exp_pc)
        else begin
            err_count++;
            $error("** Error at %0t: decoded pc %h, expected %h", $time,
                   $sampled(dec_item.pc), $sampled(exp_pc));
        end

    a_fields: assert property (@(posedge clk) disable iff (!rstn)
        dec_valid |-> dec_item == expect_decode(dec_item.pc))
        else begin
            err_count++;
            $error("** Error at %0t: wrong decode of pc %h", $time, $sampled(dec_item.pc));
        end

    a_hold_frozen: assert property (@(posedge clk) disable iff (!rstn)
        hold && dec_valid && !redirect |=> dec_valid && $stable(dec_item))
        else begin
            err_count++;
            $error("** Error at %0t: output changed under hold", $time);
        end

    a_halt: assert property (@(posedge clk) disable iff (!rstn)
        halt == (dec_valid && is_halt_word(image_word(dec_item.pc))))
        else begin
            err_count++;
            $error("** Error at %0t: halt is %b for pc %h", $time, $sampled(halt),
                   $sampled(dec_item.pc));
        end

endmodule

bind rv_front_end rv_front_checker u_checker (.*);

// File: design/rv_front_end.sv
// Front end top level: connects fetch unit, fetch buffer and decode stage to the outside ports
`timescale 1ns/1ps

module rv_front_end import rv_front_pkg::*; (
    input  logic      clk,
    input  logic      rstn,

    // Instruction memory port
    output logic      mem_req,
    output addr_t     mem_addr,
    input  logic      mem_ready,
    input  word_t     mem_rdata,

    // Taken branch or jump
    input  logic      redirect,
    input  addr_t     redirect_pc,

    // Downstream
    input  logic      hold,
    output logic      dec_valid,
    output dec_item_t dec_item,
    output logic      halt
);

    // Fetch to buffer
    logic        push;
    fetch_item_t push_item;
    logic        space;
    // Buffer to decode
    logic        pop;
    logic        head_valid;
    fetch_item_t head_item;

    rv_fetch_unit u_fetch (
        .clk         (clk),
        .rstn        (rstn),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .space       (space),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_ready   (mem_ready),
        .mem_rdata   (mem_rdata),
        .push        (push),
        .push_item   (push_item)
    );

    // Redirect empties the queue in the same cycle
    rv_fetch_buffer u_fbuf (
        .clk        (clk),
        .rstn       (rstn),
        .flush      (redirect),
        .push       (push),
        .push_item  (push_item),
        .space      (space),
        .pop        (pop),
        .head_valid (head_valid),
        .head_item  (head_item)
    );

    rv_decode_stage u_decode (
        .clk        (clk),
        .rstn       (rstn),
        .flush      (redirect),
        .head_valid (head_valid),
        .head_item  (head_item),
        .pop        (pop),
        .hold       (hold),
        .dec_valid  (dec_valid),
        .dec_item   (dec_item),
        .halt       (halt)
    );

endmodule

// File: design/rv_decode_stage.sv
// Decode stage: turns the buffer head into a registered decoded item and flags ECALL/EBREAK
`timescale 1ns/1ps

module rv_decode_stage import rv_front_pkg::*; (
    input  logic        clk,
    input  logic        rstn,

    // Redirect, empties the output register
    input  logic        flush,

    // From the fetch buffer
    input  logic        head_valid,
    input  fetch_item_t head_item,
    output logic        pop,

    // Downstream stall
    input  logic        hold,

    // Decoded output
    output logic        dec_valid,
    output dec_item_t   dec_item,
    output logic        halt
);

    word_t     instr;
    opcode_t   opcode;
    op_class_t op_class;
    // Immediates of each format, sign-extended
    word_t     imm_i;
    word_t     imm_s;
    word_t     imm_b;
    word_t     imm_u;
    word_t     imm_j;
    dec_item_t dec_next;

    assign instr  = head_item.instr;
    assign opcode = instr[6:0];

    // ##########################################################
    // Field extraction
    // ##########################################################

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    // Branch offset, bit 0 implied zero
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    // Jump offset, bit 0 implied zero
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // Opcode class
    always_comb begin
        case (opcode)
            opc_r_alu:  op_class = r_alu;
            opc_i_alu:  op_class = i_alu;
            opc_load:   op_class = load;
            opc_store:  op_class = store;
            opc_branch: op_class = branch;
            opc_jal:    op_class = jal;
            opc_jalr:   op_class = jalr;
            opc_lui:    op_class = lui;
            opc_auipc:  op_class = auipc;
            opc_system: op_class = system;
            opc_fence:  op_class = fence;
            // Includes compressed encodings, bits 1:0 not 11
            default:    op_class = illegal;
        endcase
    end

    // ##########################################################
    // Decoded item
    // ##########################################################

    always_comb begin
        dec_next.pc       = head_item.pc;
        dec_next.op_class = op_class;
        dec_next.rd       = instr[11:7];
        dec_next.rs1      = instr[19:15];
        dec_next.rs2      = instr[24:20];
        dec_next.funct3   = instr[14:12];
        // Immediate picked by format of the class
        case (op_class)
            i_alu, load, jalr, system, fence: dec_next.imm = imm_i;
            store:                            dec_next.imm = imm_s;
            branch:                           dec_next.imm = imm_b;
            lui, auipc:                       dec_next.imm = imm_u;
            jal:                              dec_next.imm = imm_j;
            // R-type and illegal carry no immediate
            default:                          dec_next.imm = '0;
        endcase
        // Classes that write rd
        dec_next.reg_write = op_class inside {r_alu, i_alu, load, jal, jalr, lui, auipc};
    end

    // ##########################################################
    // Output register
    // ##########################################################

    // Take the head when the output is free or moving on
    assign pop = head_valid && !flush && (!dec_valid || !hold);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            dec_valid <= 1'b0;
        end else if (flush) begin
            dec_valid <= 1'b0;
        end else if (pop) begin
            dec_valid <= 1'b1;
        end else if (!hold) begin
            // Consumed downstream, nothing new behind it
            dec_valid <= 1'b0;
        end
    end

    // Only loads on a pop, so hold freezes it
    always_ff @(posedge clk) begin
        if (pop) begin
            dec_item <= dec_next;
        end
    end

    // ECALL has imm 0, EBREAK imm 1, both with funct3 zero
    assign halt = dec_valid
                  && (dec_item.op_class == system)
                  && (dec_item.funct3 == 3'b000)
                  && ((dec_item.imm == word_t'(0)) || (dec_item.imm == word_t'(1)));

endmodule

// File: design/rv_fetch_buffer.sv
// Fetch buffer: in-order queue of fetched words between the fetch unit and the decode stage
`timescale 1ns/1ps
`include "rv_front_config.svh"

module rv_fetch_buffer import rv_front_pkg::*; (
    input  logic        clk,
    input  logic        rstn,

    // Redirect, drops every queued word
    input  logic        flush,

    // From the fetch unit
    input  logic        push,
    input  fetch_item_t push_item,
    output logic        space,

    // To the decode stage
    input  logic        pop,
    output logic        head_valid,
    output fetch_item_t head_item
);

    localparam int depth = `RV_FBUF_DEPTH;
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    // Entry storage
    fetch_item_t      entries [depth];
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    // Number of valid entries
    logic [cnt_w-1:0] count;
    logic             do_push;
    logic             do_pop;

    // Pointer increment with wrap at depth
    function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // ##########################################################
    // Status
    // ##########################################################

    assign head_valid = (count != '0);
    assign head_item  = entries[rd_ptr];

    // Free entry now, or the head drains this cycle
    assign space = (count < cnt_w'(depth)) || pop;

    assign do_push = push && !flush;
    assign do_pop  = pop && head_valid && !flush;

    // ##########################################################
    // Pointers and count
    // ##########################################################

    always_ff @(posedge clk) begin
        if (!rstn || flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            // Push and pop together leave the count as it is
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Payload write
    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wr_ptr] <= push_item;
        end
    end

endmodule

// File: design/rv_fetch_unit.sv
// Fetch unit: sequences the PC, issues one instruction read at a time and handles redirects
`timescale 1ns/1ps
`include "rv_front_config.svh"

module rv_fetch_unit import rv_front_pkg::*; (
    input  logic        clk,
    input  logic        rstn,

    // Taken branch or jump from downstream
    input  logic        redirect,
    input  addr_t       redirect_pc,

    // Room in the fetch buffer
    input  logic        space,

    // Instruction memory port
    output logic        mem_req,
    output addr_t       mem_addr,
    input  logic        mem_ready,
    input  word_t       mem_rdata,

    // Into the fetch buffer
    output logic        push,
    output fetch_item_t push_item
);

    // ##########################################################
    // State
    // ##########################################################

    fetch_state_t state;
    // Next address to fetch
    addr_t        pc;
    // Address of the read in flight
    addr_t        fetch_addr;

    // ##########################################################
    // Memory port and push
    // ##########################################################

    // Request held until the ready pulse, dropped in the ready cycle itself
    assign mem_req  = (state != idle) && !mem_ready;
    // Address stays on the captured value for the whole read
    assign mem_addr = fetch_addr;

    // Word goes to the buffer unless squashed by a redirect in the same cycle
    assign push = (state == wait_mem) && mem_ready && !redirect;

    // Tag with the address it came from
    assign push_item.pc    = fetch_addr;
    assign push_item.instr = mem_rdata;

    // ##########################################################
    // Sequencer
    // ##########################################################

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state      <= idle;
            pc         <= `RV_PC_RESET;
            fetch_addr <= `RV_PC_RESET;
        end else begin
            case (state)
                idle: begin
                    // Redirect wins over starting a read from the old stream
                    if (redirect) begin
                        pc <= redirect_pc;
                    end else if (space) begin
                        fetch_addr <= pc;
                        state      <= wait_mem;
                    end
                end
                wait_mem: begin
                    if (redirect) begin
                        pc <= redirect_pc;
                        // Read still open, its word must be thrown away later
                        state <= mem_ready ? idle : drop;
                    end else if (mem_ready) begin
                        // Advance from the fetched address, not from pc
                        pc    <= fetch_addr + addr_t'(`RV_ILEN_BYTES);
                        state <= idle;
                    end
                end
                drop: begin
                    // A further redirect only moves the target
                    if (redirect) begin
                        pc <= redirect_pc;
                    end
                    if (mem_ready) begin
                        state <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

// File: design/rv_front_pkg.sv
// Shared types of the front end: vector typedefs, opcode classes and the items passed along
package rv_front_pkg;

`include "rv_front_config.svh"

    // ##########################################################
    // Vector types
    // ##########################################################

    // Data or instruction word
    typedef logic [`RV_XLEN-1:0] word_t;
    // Byte address or PC
    typedef logic [`RV_XLEN-1:0] addr_t;
    // Register number x0..x31
    typedef logic [4:0]          reg_addr_t;
    // Minor opcode
    typedef logic [2:0]          funct3_t;
    // Major opcode, instr[6:0]
    typedef logic [6:0]          opcode_t;

    // RV32I major opcodes
    localparam opcode_t opc_r_alu  = 7'b011_0011;
    localparam opcode_t opc_i_alu  = 7'b001_0011;
    localparam opcode_t opc_load   = 7'b000_0011;
    localparam opcode_t opc_store  = 7'b010_0011;
    localparam opcode_t opc_branch = 7'b110_0011;
    localparam opcode_t opc_jal    = 7'b110_1111;
    localparam opcode_t opc_jalr   = 7'b110_0111;
    localparam opcode_t opc_lui    = 7'b011_0111;
    localparam opcode_t opc_auipc  = 7'b001_0111;
    // ECALL, EBREAK and CSR space
    localparam opcode_t opc_system = 7'b111_0011;
    localparam opcode_t opc_fence  = 7'b000_1111;

    // ##########################################################
    // Enums and items
    // ##########################################################

    // Decoded instruction class
    typedef enum logic [3:0] {
        r_alu, i_alu, load, store, branch, jal, jalr,
        lui, auipc, system, fence, illegal
    } op_class_t;

    // Fetch sequencer states
    typedef enum logic [1:0] {
        idle,
        wait_mem,
        // Read in flight whose word is thrown away
        drop
    } fetch_state_t;

    // Fetched word tagged with its address
    typedef struct packed {
        addr_t pc;
        word_t instr;
    } fetch_item_t;

    // Registered decode output
    typedef struct packed {
        addr_t     pc;
        op_class_t op_class;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        funct3_t   funct3;
        word_t     imm;
        logic      reg_write;
    } dec_item_t;

endpackage

// File: design/rv_front_config.svh
// Widths, reset values and sizes of the fetch/decode front end, included by the package and RTL
`ifndef RV_FRONT_CONFIG_SVH
`define RV_FRONT_CONFIG_SVH

// ##########################################################
// Datapath
// ##########################################################

// Data, instruction and address width
`define RV_XLEN 32

// PC step between sequential instructions, in bytes
`define RV_ILEN_BYTES 4

// ##########################################################
// Fetch side
// ##########################################################

// First fetch address after reset
`define RV_PC_RESET 32'h0000_0000

// Fetch buffer entries, IF/ID register plus its skid slot
`define RV_FBUF_DEPTH 2

`endif
